/* verilog.f */
+incdir+bench
src/cpu_pkg.sv
src/dec_exe_if.sv
src/fetch_pc.sv
src/decode.sv
src/regfile.sv
src/execute.sv
src/result.sv
src/cpu_top.sv
bench/cpu_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module cpu_tb -f verilog.f -o cpu_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/cpu_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulator exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "Simulation completed successfully"; then
	exit 0
fi
exit 1

/* bench/tb_programs.svh */
// Each program has a name, 16 code words from address 0, data words 0 to 3,
// its stores in issue order as address and data, a store count, a load count and the halt PC
task automatic fill_programs();
	prog_name[0] = "arith";
	prog_code[0] = '{16'hB1F0, 16'hA17F, 16'hB220, 16'h0312, 16'h9300, 16'hB410, 16'hA480,
		16'h1542, 16'h9501, 16'h2612, 16'h9602, 16'h1721, 16'h9703, 16'hF000, 16'hF000, 16'hF000};
	prog_data[0] = '{16'h1234, 16'hBEEF, 16'h0F0F, 16'hCAFE};
	exp_addr[0] = '{16'h0000, 16'h0002, 16'h0004, 16'h0006, 16'h0000, 16'h0000};
	exp_data[0] = '{16'h7FFF, 16'h8000, 16'h7FD0, 16'h8030, 16'h0000, 16'h0000};
	exp_cnt[0] = 4;
	exp_loads[0] = 0;
	exp_hlt[0] = 16'h001A;

	prog_name[1] = "shift";
	prog_code[1] = '{16'hB121, 16'hA184, 16'h4214, 16'h9200, 16'h5313, 16'h9301, 16'h6418,
		16'h9402, 16'h6511, 16'h9503, 16'h561F, 16'h9604, 16'hF000, 16'hF000, 16'hF000, 16'hF000};
	prog_data[1] = '{16'h1234, 16'hBEEF, 16'h0F0F, 16'hCAFE};
	exp_addr[1] = '{16'h0000, 16'h0002, 16'h0004, 16'h0006, 16'h0008, 16'h0000};
	exp_data[1] = '{16'h4210, 16'hF084, 16'h2184, 16'hC210, 16'hFFFF, 16'h0000};
	exp_cnt[1] = 5;
	exp_loads[1] = 0;
	exp_hlt[1] = 16'h0018;

	prog_name[2] = "memory"; // Negative offsets and writes to r0
	prog_code[2] = '{16'hB110, 16'hB2CD, 16'hA2AB, 16'h9211, 16'h8301, 16'h9312, 16'h8418,
		16'h941F, 16'hB055, 16'h8003, 16'h9013, 16'hF000, 16'hF000, 16'hF000, 16'hF000, 16'hF000};
	prog_data[2] = '{16'h1234, 16'hBEEF, 16'h0F0F, 16'hCAFE};
	exp_addr[2] = '{16'h0012, 16'h0014, 16'h000E, 16'h0016, 16'h0000, 16'h0000};
	exp_data[2] = '{16'hABCD, 16'hBEEF, 16'h1234, 16'h0000, 16'h0000, 16'h0000};
	exp_cnt[2] = 4;
	exp_loads[2] = 3;
	exp_hlt[2] = 16'h0016;

	prog_name[3] = "branch"; // Every marker sits on a skipped path
	prog_code[3] = '{16'hB105, 16'h0300, 16'hC001, 16'hC201, 16'h9000, 16'hC601, 16'hCE01,
		16'h9001, 16'h1401, 16'hC201, 16'hC001, 16'h9002, 16'h2511, 16'hC601, 16'h9003, 16'hF000};
	prog_data[3] = '{16'h1234, 16'hBEEF, 16'h0F0F, 16'hCAFE};
	exp_addr[3] = '{16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000};
	exp_data[3] = '{16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000};
	exp_cnt[3] = 0;
	exp_loads[3] = 0;
	exp_hlt[3] = 16'h001E;

	prog_name[4] = "call";
	prog_code[4] = '{16'h3123, 16'hB60C, 16'hE500, 16'hDE60, 16'h9901, 16'hF000, 16'h9500,
		16'hA87F, 16'h0988, 16'h2A88, 16'hCC01, 16'h9903, 16'h7566, 16'hB702, 16'h0557, 16'hDE50};
	prog_data[4] = '{16'h1234, 16'hBEEF, 16'h0F0F, 16'hCAFE};
	exp_addr[4] = '{16'h0000, 16'h0002, 16'h0000, 16'h0000, 16'h0000, 16'h0000};
	exp_data[4] = '{16'h0006, 16'h7FFF, 16'h0000, 16'h0000, 16'h0000, 16'h0000};
	exp_cnt[4] = 2;
	exp_loads[4] = 0;
	exp_hlt[4] = 16'h000A;
endtask

/* bench/cpu_tb.sv */
`timescale 1ns/1ns

module cpu_tb;
	import cpu_pkg::*;

	localparam int NPROG = 5;
	localparam int HALT_TIMEOUT = 200;

	logic clk;
	logic rst_n_i;
	word_t imem_addr;
	word_t imem_data;
	word_t dmem_addr;
	word_t dmem_wdata;
	word_t dmem_rdata;
	word_t pc;
	logic dmem_rd;
	logic dmem_wr;
	logic hlt;
	word_t imem [256];
	word_t dmem [256];
	word_t dmem_init [256];
	word_t st_addr_q [$];
	word_t st_data_q [$];
	int load_cnt;
	int errors;
	int failed;

	string prog_name [NPROG];
	word_t prog_code [NPROG][16];
	word_t prog_data [NPROG][4];
	word_t exp_addr [NPROG][6];
	word_t exp_data [NPROG][6];
	int exp_cnt [NPROG];
	int exp_loads [NPROG];
	word_t exp_hlt [NPROG];

	`include "tb_programs.svh"

	cpu_top dut0 (
		.clk(clk), .rst_n_i(rst_n_i),
		.imem_addr_o(imem_addr), .imem_data_i(imem_data),
		.dmem_addr_o(dmem_addr), .dmem_wdata_o(dmem_wdata), .dmem_rdata_i(dmem_rdata),
		.dmem_rd_o(dmem_rd), .dmem_wr_o(dmem_wr),
		.hlt_o(hlt), .pc_o(pc)
	);

	assign imem_data = imem[imem_addr[8:1]]; // Word memories behind byte addresses
	assign dmem_rdata = dmem[dmem_addr[8:1]];

	always #5 clk = ~clk;

	// Preload during reset and log data accesses afterwards
	always @(posedge clk) begin
		if (!rst_n_i) begin
			dmem <= dmem_init;
			st_addr_q.delete();
			st_data_q.delete();
			load_cnt = 0;
		end else begin
			if (dmem_wr) begin
				dmem[dmem_addr[8:1]] <= dmem_wdata;
				st_addr_q.push_back(dmem_addr);
				st_data_q.push_back(dmem_wdata);
			end
			if (dmem_rd) begin
				load_cnt++;
			end
		end
	end

	task automatic check_value(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("Error: %s is %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic load_memories(input int p);
		for (int i = 0; i < 256; i++) begin
			imem[i] = {8'hF0, i[7:0]}; // HLT beyond the program
			dmem_init[i] = {i[7:0], ~i[7:0]};
		end
		for (int i = 0; i < 16; i++) begin
			imem[i] = prog_code[p][i];
		end
		for (int i = 0; i < 4; i++) begin
			dmem_init[i] = prog_data[p][i];
		end
	endtask

	task automatic run_program(input int p);
		int cycles;
		int start_errors;
		start_errors = errors;
		@(posedge clk);
		#1 rst_n_i = 1'b0;
		load_memories(p);
		repeat (4) @(posedge clk);
		#1 rst_n_i = 1'b1;
		cycles = 0;
		while (hlt !== 1'b1 && cycles < HALT_TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		if (hlt !== 1'b1) begin
			$display("Timeout: program %s did not halt within %0d cycles",
				prog_name[p], HALT_TIMEOUT);
			errors++;
		end else begin
			check_value("pc_o", pc, exp_hlt[p]);
			repeat (5) begin // Halt must hold
				@(negedge clk);
				check_value("hlt_o", {15'd0, hlt}, 16'h0001);
				check_value("pc_o", pc, exp_hlt[p]);
			end
			check_value("store count", 16'(st_addr_q.size()), 16'(exp_cnt[p]));
			check_value("load count", 16'(load_cnt), 16'(exp_loads[p]));
			for (int k = 0; k < exp_cnt[p] && k < st_addr_q.size(); k++) begin
				check_value("dmem_addr_o", st_addr_q[k], exp_addr[p][k]);
				check_value("dmem_wdata_o", st_data_q[k], exp_data[p][k]);
			end
		end
		if (errors == start_errors) begin
			$display("Program %s: ok", prog_name[p]);
		end else begin
			$display("Program %s: %0d errors", prog_name[p], errors - start_errors);
			failed++;
		end
	endtask

	initial begin
		clk = 1'b0;
		rst_n_i = 1'b0;
		errors = 0;
		failed = 0;
		fill_programs();
		load_memories(0);
		for (int p = 0; p < NPROG; p++) begin
			run_program(p);
		end
		$display("Programs run: %0d, passed: %0d, failed: %0d", NPROG, NPROG - failed, failed);
		if (errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

/* src/cpu_top.sv */
`timescale 1ns/1ns

module cpu_top #(
	parameter cpu_pkg::word_t RESET_PC = '0
) (
	input  logic           clk,
	input  logic           rst_n_i,
	output cpu_pkg::word_t imem_addr_o,
	input  cpu_pkg::word_t imem_data_i,
	output cpu_pkg::word_t dmem_addr_o,
	output cpu_pkg::word_t dmem_wdata_o,
	input  cpu_pkg::word_t dmem_rdata_i,
	output logic           dmem_rd_o,
	output logic           dmem_wr_o,
	output logic           hlt_o,
	output cpu_pkg::word_t pc_o
);
	import cpu_pkg::*;

	reg_idx_t rs_idx;
	reg_idx_t rt_idx;
	word_t rs_val;
	word_t rt_val;
	word_t pc_plus2;
	word_t alu_w;
	flags_t flags_w;
	logic wb_we;
	reg_idx_t wb_dst;
	word_t wb_data;

	dec_exe_if ex_bus ();

	assign imem_addr_o = pc_o;

	fetch_pc #(.RESET_PC(RESET_PC)) fetch0 (
		.clk(clk), .rst_n_i(rst_n_i),
		.instr_i(imem_data_i), .rs_val_i(rs_val), .flags_i(flags_w),
		.pc_o(pc_o), .pc_plus2_o(pc_plus2), .hlt_o(hlt_o)
	);

	decode dec0 (
		.instr_i(imem_data_i),
		.rs_idx_o(rs_idx), .rt_idx_o(rt_idx),
		.rs_val_i(rs_val), .rt_val_i(rt_val),
		.ex(ex_bus.dec)
	);

	regfile rf0 (
		.clk(clk), .rst_n_i(rst_n_i),
		.rs_idx_i(rs_idx), .rt_idx_i(rt_idx),
		.rs_val_o(rs_val), .rt_val_o(rt_val),
		.we_i(wb_we), .dst_i(wb_dst), .wdata_i(wb_data)
	);

	execute exe0 (
		.clk(clk), .rst_n_i(rst_n_i),
		.ex(ex_bus.exe),
		.alu_o(alu_w), .flags_o(flags_w),
		.dmem_addr_o(dmem_addr_o), .dmem_wdata_o(dmem_wdata_o),
		.dmem_rd_o(dmem_rd_o), .dmem_wr_o(dmem_wr_o)
	);

	result res0 (
		.ex(ex_bus.res),
		.alu_i(alu_w), .mem_i(dmem_rdata_i), .pc_plus2_i(pc_plus2),
		.we_o(wb_we), .dst_o(wb_dst), .wdata_o(wb_data)
	);

endmodule

/* src/result.sv */
`timescale 1ns/1ns

module result (
	dec_exe_if.res            ex,
	input  cpu_pkg::word_t    alu_i,
	input  cpu_pkg::word_t    mem_i,
	input  cpu_pkg::word_t    pc_plus2_i,
	output logic              we_o,
	output cpu_pkg::reg_idx_t dst_o,
	output cpu_pkg::word_t    wdata_o
);
	import cpu_pkg::*;

	word_t byte_w;

	// Operand b marks the byte of a that survives
	assign byte_w = (ex.a & ex.b) | ({ex.byte_imm, ex.byte_imm} & ~ex.b);

	always_comb begin
		case (ex.wb_sel)
			WB_MEM:  wdata_o = mem_i;
			WB_BYTE: wdata_o = byte_w;
			WB_PC:   wdata_o = pc_plus2_i; // Return address for PCS
			default: wdata_o = alu_i;
		endcase
	end

	assign we_o = ex.reg_we;
	assign dst_o = ex.dst;

endmodule

/* src/execute.sv */
`timescale 1ns/1ns

module execute (
	input  logic            clk,
	input  logic            rst_n_i,
	dec_exe_if.exe          ex,
	output cpu_pkg::word_t  alu_o,
	output cpu_pkg::flags_t flags_o,
	output cpu_pkg::word_t  dmem_addr_o,
	output cpu_pkg::word_t  dmem_wdata_o,
	output logic            dmem_rd_o,
	output logic            dmem_wr_o
);
	import cpu_pkg::*;

	logic sub_w;
	logic ovf_w;
	logic [3:0] sh_w;
	word_t b_eff;
	word_t sum_w;
	word_t sat_w;
	word_t res_w;
	logic [2*WORD_W-1:0] rot_w;
	flags_t flags_q;

	// Shared adder, SUB as a + ~b + 1
	assign sub_w = (ex.alu_op == ALU_SUB);
	assign b_eff = sub_w ? ~ex.b : ex.b;
	assign sum_w = ex.a + b_eff + {{(WORD_W-1){1'b0}}, sub_w};
	assign ovf_w = (ex.a[WORD_W-1] == b_eff[WORD_W-1]) && (sum_w[WORD_W-1] != ex.a[WORD_W-1]);
	assign sat_w = ovf_w ? (ex.a[WORD_W-1] ? 16'h8000 : 16'h7FFF) : sum_w;

	assign sh_w = ex.b[3:0];
	assign rot_w = {ex.a, ex.a} >> sh_w;

	always_comb begin
		case (ex.alu_op)
			ALU_ADD, ALU_SUB: res_w = sat_w;
			ALU_XOR: res_w = ex.a ^ ex.b;
			ALU_SLL: res_w = ex.a << sh_w;
			ALU_SRA: res_w = $signed(ex.a) >>> sh_w; // Sign fill
			ALU_ROR: res_w = rot_w[WORD_W-1:0];
			default: res_w = ex.b;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			flags_q <= '0;
		end else begin
			case (ex.alu_op)
				ALU_ADD, ALU_SUB: begin
					flags_q.z <= (res_w == '0);
					flags_q.v <= ovf_w;
					flags_q.n <= res_w[WORD_W-1];
				end
				ALU_XOR, ALU_SLL, ALU_SRA, ALU_ROR: flags_q.z <= (res_w == '0);
				default: ; // Flags held
			endcase
		end
	end

	assign alu_o = res_w;
	assign flags_o = flags_q;
	assign dmem_addr_o = sum_w; // rs + imm*2 for LW and SW
	assign dmem_wdata_o = ex.store_data;
	assign dmem_rd_o = ex.mem_rd;
	assign dmem_wr_o = ex.mem_wr;

endmodule

/* src/regfile.sv */
`timescale 1ns/1ns

module regfile (
	input  logic              clk,
	input  logic              rst_n_i,
	input  cpu_pkg::reg_idx_t rs_idx_i,
	input  cpu_pkg::reg_idx_t rt_idx_i,
	output cpu_pkg::word_t    rs_val_o,
	output cpu_pkg::word_t    rt_val_o,
	input  logic              we_i,
	input  cpu_pkg::reg_idx_t dst_i,
	input  cpu_pkg::word_t    wdata_i
);
	import cpu_pkg::*;

	word_t regs [NUM_REGS];

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we_i && dst_i != '0) begin
			regs[dst_i] <= wdata_i;
		end
	end

	// R0 hardwired
	assign rs_val_o = (rs_idx_i == '0) ? '0 : regs[rs_idx_i];
	assign rt_val_o = (rt_idx_i == '0) ? '0 : regs[rt_idx_i];

endmodule

/* src/decode.sv */
`timescale 1ns/1ns

// Formats: op rd rs rt | op rd rs imm4 | op rd imm8 | op cc off9 | op cc x rs x
// SW stores the register in [11:8]
module decode (
	input  cpu_pkg::word_t    instr_i,
	output cpu_pkg::reg_idx_t rs_idx_o,
	output cpu_pkg::reg_idx_t rt_idx_o,
	input  cpu_pkg::word_t    rs_val_i,
	input  cpu_pkg::word_t    rt_val_i,
	dec_exe_if.dec            ex
);
	import cpu_pkg::*;

	opcode_e op;
	word_t imm_sext;

	assign op = opcode_e'(instr_i[15:12]);
	assign imm_sext = {{12{instr_i[3]}}, instr_i[3:0]};

	// Byte loads read their own destination to keep the other byte
	assign rs_idx_o = (op == OP_LHB || op == OP_LLB) ? instr_i[11:8] : instr_i[7:4];
	assign rt_idx_o = (op == OP_SW) ? instr_i[11:8] : instr_i[3:0];

	assign ex.a = rs_val_i;
	assign ex.store_data = rt_val_i;
	assign ex.byte_imm = instr_i[7:0];
	assign ex.dst = instr_i[11:8];

	always_comb begin
		ex.alu_op = ALU_PASS;
		ex.b = rt_val_i;
		ex.wb_sel = WB_ALU;
		ex.reg_we = 1'b0;
		ex.mem_rd = 1'b0;
		ex.mem_wr = 1'b0;
		case (op)
			OP_ADD: begin
				ex.alu_op = ALU_ADD;
				ex.reg_we = 1'b1;
			end
			OP_SUB: begin
				ex.alu_op = ALU_SUB;
				ex.reg_we = 1'b1;
			end
			OP_XOR: begin
				ex.alu_op = ALU_XOR;
				ex.reg_we = 1'b1;
			end
			OP_SLL, OP_SRA, OP_ROR: begin
				ex.alu_op = (op == OP_SLL) ? ALU_SLL : (op == OP_SRA) ? ALU_SRA : ALU_ROR;
				ex.b = imm_sext;
				ex.reg_we = 1'b1;
			end
			OP_LW: begin
				ex.b = imm_sext << 1;
				ex.wb_sel = WB_MEM;
				ex.reg_we = 1'b1;
				ex.mem_rd = 1'b1;
			end
			OP_SW: begin
				ex.b = imm_sext << 1;
				ex.mem_wr = 1'b1;
			end
			OP_LHB, OP_LLB: begin
				ex.b = (op == OP_LHB) ? 16'h00FF : 16'hFF00; // Byte to keep
				ex.wb_sel = WB_BYTE;
				ex.reg_we = 1'b1;
			end
			OP_PCS: begin
				ex.wb_sel = WB_PC;
				ex.reg_we = 1'b1;
			end
			default: ; // Reserved, B, BR, HLT
		endcase
	end

endmodule

/* src/fetch_pc.sv */
`timescale 1ns/1ns

module fetch_pc #(
	parameter cpu_pkg::word_t RESET_PC = '0
) (
	input  logic           clk,
	input  logic           rst_n_i,
	input  cpu_pkg::word_t instr_i,
	input  cpu_pkg::word_t rs_val_i,
	input  cpu_pkg::flags_t flags_i,
	output cpu_pkg::word_t pc_o,
	output cpu_pkg::word_t pc_plus2_o,
	output logic           hlt_o
);
	import cpu_pkg::*;

	opcode_e op;
	ccode_e cc;
	word_t pc_q;
	word_t br_off;
	word_t pc_next;
	logic taken;

	assign op = opcode_e'(instr_i[15:12]);
	assign cc = ccode_e'(instr_i[11:9]);
	assign br_off = {{6{instr_i[8]}}, instr_i[8:0], 1'b0}; // Word offset to bytes

	always_comb begin
		case (cc)
			CC_NEQ:  taken = ~flags_i.z;
			CC_EQ:   taken = flags_i.z;
			CC_GT:   taken = ~flags_i.z & ~flags_i.n;
			CC_LT:   taken = flags_i.n;
			CC_GTE:  taken = flags_i.z | ~flags_i.n;
			CC_LTE:  taken = flags_i.z | flags_i.n;
			CC_OVFL: taken = flags_i.v;
			default: taken = 1'b1;
		endcase
	end

	always_comb begin
		pc_next = pc_plus2_o;
		if (op == OP_HLT) begin
			pc_next = pc_q; // Frozen on halt
		end else if (op == OP_B && taken) begin
			pc_next = pc_plus2_o + br_off;
		end else if (op == OP_BR && taken) begin
			pc_next = rs_val_i;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			pc_q <= RESET_PC;
		end else begin
			pc_q <= pc_next;
		end
	end

	assign pc_o = pc_q;
	assign pc_plus2_o = pc_q + 16'd2;
	assign hlt_o = (op == OP_HLT);

endmodule

/* src/dec_exe_if.sv */
`timescale 1ns/1ns

interface dec_exe_if;
	import cpu_pkg::*;

	alu_op_e alu_op;
	word_t a;
	word_t b; // Register, immediate or byte keep mask
	logic [BYTE_W-1:0] byte_imm;
	word_t store_data;
	wb_sel_e wb_sel;
	logic reg_we;
	reg_idx_t dst;
	logic mem_rd;
	logic mem_wr;

	modport dec (output alu_op, a, b, byte_imm, store_data, wb_sel, reg_we, dst, mem_rd, mem_wr);

	modport exe (input alu_op, a, b, store_data, mem_rd, mem_wr);

	modport res (input a, b, byte_imm, wb_sel, reg_we, dst);

endinterface

/* src/cpu_pkg.sv */
package cpu_pkg;

	localparam int WORD_W    = 16;
	localparam int BYTE_W    = 8;
	localparam int REG_IDX_W = 4;
	localparam int NUM_REGS  = 1 << REG_IDX_W;

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [REG_IDX_W-1:0] reg_idx_t;

	// Instruction word [15:12]
	typedef enum logic [3:0] {
		OP_ADD  = 4'd0,
		OP_SUB  = 4'd1,
		OP_XOR  = 4'd2,
		OP_RSV3 = 4'd3,
		OP_SLL  = 4'd4,
		OP_SRA  = 4'd5,
		OP_ROR  = 4'd6,
		OP_RSV7 = 4'd7,
		OP_LW   = 4'd8,
		OP_SW   = 4'd9,
		OP_LHB  = 4'd10,
		OP_LLB  = 4'd11,
		OP_B    = 4'd12,
		OP_BR   = 4'd13,
		OP_PCS  = 4'd14,
		OP_HLT  = 4'd15
	} opcode_e;

	// Branch condition, instruction word [11:9]
	typedef enum logic [2:0] {
		CC_NEQ    = 3'd0,
		CC_EQ     = 3'd1,
		CC_GT     = 3'd2,
		CC_LT     = 3'd3,
		CC_GTE    = 3'd4,
		CC_LTE    = 3'd5,
		CC_OVFL   = 3'd6,
		CC_UNCOND = 3'd7
	} ccode_e;

	typedef struct packed {
		logic z;
		logic v;
		logic n;
	} flags_t;

	typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_XOR, ALU_SLL, ALU_SRA, ALU_ROR, ALU_PASS} alu_op_e;

	typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_BYTE, WB_PC} wb_sel_e;

endpackage
